//--- Makefile
# Verilator lint and simulation of the array heap
VERILATOR ?= verilator
TOP ?= arrayHeapTb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+source
source/arrayHeapPkg.sv
source/heapInterfaces.sv
source/heapAllocator.sv
source/arrayStore.sv
source/heapCommandDecoder.sv
source/arrayHeap.sv
tests/clockGen.sv
tests/arrayHeap_assertions.sv
tests/arrayHeapTb.sv

//--- source/arrayHeap.sv
// -----------------------------------------------
// Top level of the array heap
// A start pulse gives done, dataOut and error one cycle later
// -----------------------------------------------

module arrayHeap (
  input  logic clock,
  input  logic resetN,
  input  logic start,
  input  arrayHeapPkg::heapAction action,
  input  arrayHeapPkg::arrayNumber array,
  input  arrayHeapPkg::elementIndex index,
  input  arrayHeapPkg::elementData dataIn,
  output arrayHeapPkg::elementData dataOut,
  output arrayHeapPkg::heapError error,
  output logic done
);

  allocIf allocBus ();
  storeIf storeBus ();

  heapCommandDecoder decoder (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .done    (done),
    .alloc   (allocBus.decoder),
    .store   (storeBus.decoder)
  );

  heapAllocator allocator (
    .clock  (clock),
    .resetN (resetN),
    .bus    (allocBus.allocator)
  );

  arrayStore store (
    .clock  (clock),
    .resetN (resetN),
    .bus    (storeBus.store)
  );

endmodule

//--- source/arrayHeapPkg.sv
// -----------------------------------------------
// Shared types of the array heap
// Action and error codes plus the sized vector types
// -----------------------------------------------
`include "arrayHeap_consts.svh"

package arrayHeapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumber;   // Which array
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex;  // Position within an array
  typedef logic [`HEAP_DATA_BITS-1:0] elementData;    // One element
  typedef logic [`HEAP_INDEX_BITS:0] arraySize;       // One bit wider so a full 8 fits

  // -----------------------------------------------
  // Command codes that the decoder accepts
  // -----------------------------------------------
  typedef enum logic [4:0] {
    actClear    = 5'd1,   // Free every array
    actWrite    = 5'd2,
    actRead     = 5'd3,
    actSize     = 5'd4,
    actFind     = 5'd7,   // Last matching position plus one
    actPush     = 5'd14,
    actPop      = 5'd15,
    actAlloc    = 5'd18,
    actFree     = 5'd19,
    actAdd      = 5'd20,
    actSubtract = 5'd22,
    actOr       = 5'd28,
    actXor      = 5'd29,
    actAnd      = 5'd30
  } heapAction;

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,
    outOfBounds  = 3'd2,
    arrayFull    = 3'd3,
    arrayEmpty   = 3'd4,
    outOfMemory  = 3'd5,
    badAction    = 3'd6
  } heapError;

endpackage

//--- source/arrayHeap_consts.svh
// -----------------------------------------------
// Width and size constants for the array heap
// Include wherever an array, index or element is sized
// -----------------------------------------------
`ifndef ARRAYHEAP_CONSTS_SVH
`define ARRAYHEAP_CONSTS_SVH

`define HEAP_ARRAY_BITS 2                         // Bits in an array number
`define HEAP_INDEX_BITS 3                         // Bits in an element index
`define HEAP_DATA_BITS 12                         // Bits in one element

// -----------------------------------------------
// Derived counts
// -----------------------------------------------
`define HEAP_ARRAY_COUNT (1 << `HEAP_ARRAY_BITS)  // Arrays held by the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS) // Maximum elements per array

`endif

//--- source/arrayStore.sv
// -----------------------------------------------
// Element memory and array sizes
// Computes every action's reply and applies it when enabled
// -----------------------------------------------
`include "arrayHeap_consts.svh"

module arrayStore (
  input logic clock,
  input logic resetN,
  storeIf.store bus
);

  arrayHeapPkg::elementData memory [`HEAP_ARRAY_COUNT][`HEAP_ARRAY_LENGTH];
  arrayHeapPkg::arraySize sizes [`HEAP_ARRAY_COUNT];

  arrayHeapPkg::elementData element;     // Addressed element
  arrayHeapPkg::elementData popped;      // Last element of the array
  arrayHeapPkg::elementIndex lastIndex;
  arrayHeapPkg::elementIndex endIndex;   // Slot a push fills
  arrayHeapPkg::arraySize findPos;
  arrayHeapPkg::arraySize writeSize;     // Size after a write at index
  logic pastEnd;

  assign bus.size = sizes[bus.array];
  assign element = memory[bus.array][bus.index];
  assign lastIndex = arrayHeapPkg::elementIndex'(bus.size - 1'b1);
  assign endIndex = arrayHeapPkg::elementIndex'(bus.size);
  assign popped = memory[bus.array][lastIndex];
  assign writeSize = arrayHeapPkg::arraySize'(bus.index) + 1'b1;
  assign pastEnd = (arrayHeapPkg::arraySize'(bus.index) >= bus.size);

  // Highest match wins as the loop climbs
  always_comb begin
    findPos = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      if (arrayHeapPkg::arraySize'(i) < bus.size && memory[bus.array][i] == bus.data) begin
        findPos = arrayHeapPkg::arraySize'(i + 1);
      end
    end
  end

  // -----------------------------------------------
  // Reply for each action
  // -----------------------------------------------
  always_comb begin
    case (bus.action)
      arrayHeapPkg::actWrite:    bus.result = bus.data;
      arrayHeapPkg::actPush:     bus.result = bus.data;
      arrayHeapPkg::actRead:     bus.result = element;
      arrayHeapPkg::actSize:     bus.result = arrayHeapPkg::elementData'(bus.size);
      arrayHeapPkg::actFind:     bus.result = arrayHeapPkg::elementData'(findPos);
      arrayHeapPkg::actPop:      bus.result = popped;
      arrayHeapPkg::actAdd:      bus.result = element + bus.data;  // Wraps at 12 bits
      arrayHeapPkg::actSubtract: bus.result = element - bus.data;
      arrayHeapPkg::actOr:       bus.result = element | bus.data;
      arrayHeapPkg::actXor:      bus.result = element ^ bus.data;
      arrayHeapPkg::actAnd:      bus.result = element & bus.data;
      default:                   bus.result = '0;
    endcase
  end

  // -----------------------------------------------
  // Size updates
  // -----------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < `HEAP_ARRAY_COUNT; a++) begin
        sizes[a] <= '0;
      end
    end else if (bus.enable) begin
      case (bus.action)
        arrayHeapPkg::actAlloc: sizes[bus.array] <= '0;   // New array starts empty
        arrayHeapPkg::actWrite: begin
          if (pastEnd) begin
            sizes[bus.array] <= writeSize;
          end
        end
        arrayHeapPkg::actPush:  sizes[bus.array] <= bus.size + 1'b1;
        arrayHeapPkg::actPop:   sizes[bus.array] <= bus.size - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (bus.enable) begin
      case (bus.action)
        arrayHeapPkg::actWrite: memory[bus.array][bus.index] <= bus.data;
        arrayHeapPkg::actPush:  memory[bus.array][endIndex] <= bus.data;
        arrayHeapPkg::actAdd, arrayHeapPkg::actSubtract, arrayHeapPkg::actOr,
        arrayHeapPkg::actXor, arrayHeapPkg::actAnd: begin
          memory[bus.array][bus.index] <= bus.result;     // Store the new value
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/heapAllocator.sv
// -----------------------------------------------
// Array allocator with allocation bits, a LIFO of freed
// arrays and a counter of arrays never yet handed out
// -----------------------------------------------
`include "arrayHeap_consts.svh"

module heapAllocator (
  input logic clock,
  input logic resetN,
  allocIf.allocator bus
);

  logic [`HEAP_ARRAY_COUNT-1:0] allocBits;                  // One bit per array
  arrayHeapPkg::arrayNumber freeStack [`HEAP_ARRAY_COUNT];  // Freed arrays with last pushed on top
  logic [`HEAP_ARRAY_BITS:0] stackTop;                      // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0] freshCount;                    // Arrays handed out fresh
  arrayHeapPkg::arrayNumber topIndex;
  logic stackEmpty;

  assign topIndex = arrayHeapPkg::arrayNumber'(stackTop - 1'b1);
  assign stackEmpty = (stackTop == '0);

  // Reuse a freed array before a fresh one
  assign bus.grantArray = stackEmpty ? freshCount[`HEAP_ARRAY_BITS-1:0] : freeStack[topIndex];
  assign bus.outOfMemory = stackEmpty && (freshCount == `HEAP_ARRAY_COUNT);
  assign bus.allocated = allocBits[bus.array];

  // -----------------------------------------------
  // Control state
  // -----------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;
      stackTop <= '0;
      freshCount <= '0;
    end else if (bus.clearReq) begin
      allocBits <= '0;
      stackTop <= '0;
      freshCount <= '0;
    end else if (bus.allocReq) begin
      allocBits[bus.grantArray] <= 1'b1;
      if (stackEmpty) begin
        freshCount <= freshCount + 1'b1;
      end else begin
        stackTop <= stackTop - 1'b1;                        // Pop the reused array
      end
    end else if (bus.freeReq) begin
      allocBits[bus.array] <= 1'b0;                         // Bit of the freed array
      stackTop <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.freeReq && !bus.clearReq) begin
      freeStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= bus.array;
    end
  end

endmodule

//--- source/heapCommandDecoder.sv
// -----------------------------------------------
// Command decoder of the array heap
// Checks each command, issues work, registers the reply
// -----------------------------------------------
`include "arrayHeap_consts.svh"

module heapCommandDecoder (
  input  logic clock,
  input  logic resetN,
  input  logic start,
  input  arrayHeapPkg::heapAction action,
  input  arrayHeapPkg::arrayNumber array,
  input  arrayHeapPkg::elementIndex index,
  input  arrayHeapPkg::elementData dataIn,
  output arrayHeapPkg::elementData dataOut,
  output arrayHeapPkg::heapError error,
  output logic done,
  allocIf.decoder alloc,
  storeIf.decoder store
);

  arrayHeapPkg::heapError errorNext;
  arrayHeapPkg::elementData resultNext;
  logic passed;
  logic beyondEnd;
  logic isAlloc;

  assign isAlloc = (action == arrayHeapPkg::actAlloc);
  assign beyondEnd = (arrayHeapPkg::arraySize'(index) >= store.size);
  assign passed = (errorNext == arrayHeapPkg::none);

  // -----------------------------------------------
  // Command checks
  // -----------------------------------------------
  always_comb begin
    errorNext = arrayHeapPkg::none;
    case (action)
      arrayHeapPkg::actClear: ;
      arrayHeapPkg::actAlloc: begin
        if (alloc.outOfMemory) errorNext = arrayHeapPkg::outOfMemory;
      end
      arrayHeapPkg::actFree, arrayHeapPkg::actWrite, arrayHeapPkg::actSize,
      arrayHeapPkg::actFind: begin
        if (!alloc.allocated) errorNext = arrayHeapPkg::notAllocated;
      end
      arrayHeapPkg::actRead, arrayHeapPkg::actAdd, arrayHeapPkg::actSubtract,
      arrayHeapPkg::actOr, arrayHeapPkg::actXor, arrayHeapPkg::actAnd: begin
        if (!alloc.allocated) errorNext = arrayHeapPkg::notAllocated;
        else if (beyondEnd) errorNext = arrayHeapPkg::outOfBounds;
      end
      arrayHeapPkg::actPush: begin
        if (!alloc.allocated) errorNext = arrayHeapPkg::notAllocated;
        else if (store.size == `HEAP_ARRAY_LENGTH) errorNext = arrayHeapPkg::arrayFull;
      end
      arrayHeapPkg::actPop: begin
        if (!alloc.allocated) errorNext = arrayHeapPkg::notAllocated;
        else if (store.size == '0) errorNext = arrayHeapPkg::arrayEmpty;
      end
      default: errorNext = arrayHeapPkg::badAction;
    endcase
  end

  // Requests only for commands that pass
  assign alloc.array = array;
  assign alloc.allocReq = start && passed && isAlloc;
  assign alloc.freeReq = start && passed && (action == arrayHeapPkg::actFree);
  assign alloc.clearReq = start && passed && (action == arrayHeapPkg::actClear);

  assign store.action = action;
  assign store.array = isAlloc ? alloc.grantArray : array;  // Alloc empties the granted array
  assign store.index = index;
  assign store.data = dataIn;
  assign store.enable = start && passed && action != arrayHeapPkg::actClear
                        && action != arrayHeapPkg::actFree;

  always_comb begin
    if (!passed) resultNext = '0;                          // Errors return zero
    else if (isAlloc) resultNext = arrayHeapPkg::elementData'(alloc.grantArray);
    else if (action == arrayHeapPkg::actClear || action == arrayHeapPkg::actFree) resultNext = '0;
    else resultNext = store.result;
  end

  // -----------------------------------------------
  // Reply register, one cycle after start
  // -----------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done <= 1'b0;
      dataOut <= '0;
      error <= arrayHeapPkg::none;
    end else begin
      done <= start;
      if (start) begin
        dataOut <= resultNext;
        error <= errorNext;
      end
    end
  end

endmodule

//--- source/heapInterfaces.sv
// -----------------------------------------------
// Internal buses of the array heap
// allocIf joins decoder and allocator, storeIf joins decoder and store
// -----------------------------------------------

interface allocIf;
  logic allocReq;                       // Commit the grant, one cycle
  logic freeReq;                        // Return array to the free stack
  logic clearReq;                       // Forget every allocation
  arrayHeapPkg::arrayNumber array;      // Array being checked or freed
  logic allocated;                      // Allocation bit of array
  arrayHeapPkg::arrayNumber grantArray; // Next array an Alloc receives
  logic outOfMemory;                    // Nothing left to grant

  modport decoder (
    output allocReq, freeReq, clearReq, array,
    input  allocated, grantArray, outOfMemory
  );

  modport allocator (
    input  allocReq, freeReq, clearReq, array,
    output allocated, grantArray, outOfMemory
  );
endinterface

interface storeIf;
  logic enable;                         // Apply action at the next edge
  arrayHeapPkg::heapAction action;
  arrayHeapPkg::arrayNumber array;
  arrayHeapPkg::elementIndex index;
  arrayHeapPkg::elementData data;
  arrayHeapPkg::arraySize size;         // Current size of array
  arrayHeapPkg::elementData result;     // Value the action returns

  modport decoder (
    output enable, action, array, index, data,
    input  size, result
  );

  modport store (
    input  enable, action, array, index, data,
    output size, result
  );
endinterface

//--- tests/arrayHeapTb.sv
// --------------------------------------------------
// Testbench of the array heap
// Directed tests then a seeded random mix checked against a model
// --------------------------------------------------
`include "arrayHeap_consts.svh"

module arrayHeapTb;

  localparam int plannedCommands = 600;           // Directed and random together

  logic clock;
  logic resetN;
  logic start;
  arrayHeapPkg::heapAction action;
  arrayHeapPkg::arrayNumber array;
  arrayHeapPkg::elementIndex index;
  arrayHeapPkg::elementData dataIn;
  arrayHeapPkg::elementData dataOut;
  arrayHeapPkg::heapError error;
  logic done;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  arrayHeapPkg::elementData modelMem [`HEAP_ARRAY_COUNT][`HEAP_ARRAY_LENGTH];
  int modelSize [`HEAP_ARRAY_COUNT];
  bit modelAlloc [`HEAP_ARRAY_COUNT];
  int modelStack [$];                             // Freed arrays in LIFO order
  int modelFresh;

  bit pending;                                    // A reply is due at the next check
  arrayHeapPkg::heapAction expAction;
  arrayHeapPkg::elementData expData;
  arrayHeapPkg::heapError expError;
  logic [31:0] seed;
  int errors;
  int testErrors;
  int totalErrors;

  // Element operations sit at entries 12 to 16
  arrayHeapPkg::heapAction actionTable [20] = '{
    arrayHeapPkg::actWrite, arrayHeapPkg::actWrite, arrayHeapPkg::actRead, arrayHeapPkg::actRead,
    arrayHeapPkg::actSize, arrayHeapPkg::actFind, arrayHeapPkg::actPush, arrayHeapPkg::actPush,
    arrayHeapPkg::actPop, arrayHeapPkg::actPop, arrayHeapPkg::actAlloc, arrayHeapPkg::actFree,
    arrayHeapPkg::actAdd, arrayHeapPkg::actSubtract, arrayHeapPkg::actOr, arrayHeapPkg::actXor,
    arrayHeapPkg::actAnd, arrayHeapPkg::heapAction'(5'd0), arrayHeapPkg::heapAction'(5'd9),
    arrayHeapPkg::actClear};

  clockGen gen (.clock(clock), .resetN(resetN));

  arrayHeap uut (
    .clock(clock), .resetN(resetN), .start(start), .action(action), .array(array),
    .index(index), .dataIn(dataIn), .dataOut(dataOut), .error(error), .done(done)
  );

  bind heapCommandDecoder arrayHeapAssertions decoderChecks (
    .clock(clock), .resetN(resetN), .start(start), .done(done),
    .storeEnable(store.enable), .error(error), .dataOut(dataOut)
  );

  function automatic int nextRandom();
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'({17'd0, seed[30:16]});
  endfunction

  task automatic reportFail(input string message);
    $display("Fail at time %0t: %s", $time, message);
    errors++;
    testErrors++;
  endtask

  task automatic applyModel(input arrayHeapPkg::heapAction act, input int arr, input int idx,
                            input arrayHeapPkg::elementData data);
    arrayHeapPkg::elementData value;
    int grant;
    expAction = act;
    expData = '0;
    expError = arrayHeapPkg::none;
    value = modelMem[arr][idx];
    if (act == arrayHeapPkg::actClear) begin
      for (int a = 0; a < `HEAP_ARRAY_COUNT; a++) modelAlloc[a] = 1'b0;
      modelStack.delete();
      modelFresh = 0;
    end else if (act == arrayHeapPkg::actAlloc) begin
      if (modelStack.size() == 0 && modelFresh == `HEAP_ARRAY_COUNT) begin
        expError = arrayHeapPkg::outOfMemory;
      end else begin
        if (modelStack.size() > 0) begin
          grant = modelStack.pop_back();          // Reuse before fresh
        end else begin
          grant = modelFresh;
          modelFresh++;
        end
        modelAlloc[grant] = 1'b1;
        modelSize[grant] = 0;
        expData = arrayHeapPkg::elementData'(grant);
      end
    end else if (!(act inside {arrayHeapPkg::actFree, arrayHeapPkg::actWrite,
        arrayHeapPkg::actRead, arrayHeapPkg::actSize, arrayHeapPkg::actFind,
        arrayHeapPkg::actPush, arrayHeapPkg::actPop, arrayHeapPkg::actAdd,
        arrayHeapPkg::actSubtract, arrayHeapPkg::actOr, arrayHeapPkg::actXor,
        arrayHeapPkg::actAnd})) begin
      expError = arrayHeapPkg::badAction;
    end else if (!modelAlloc[arr]) begin
      expError = arrayHeapPkg::notAllocated;
    end else begin
      case (act)
        arrayHeapPkg::actFree: begin
          modelAlloc[arr] = 1'b0;
          modelStack.push_back(arr);
        end
        arrayHeapPkg::actWrite: begin
          modelMem[arr][idx] = data;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
          expData = data;
        end
        arrayHeapPkg::actSize: expData = arrayHeapPkg::elementData'(modelSize[arr]);
        arrayHeapPkg::actFind: begin
          for (int i = 0; i < modelSize[arr]; i++) begin
            if (modelMem[arr][i] == data) expData = arrayHeapPkg::elementData'(i + 1);
          end
        end
        arrayHeapPkg::actPush: begin
          if (modelSize[arr] == `HEAP_ARRAY_LENGTH) begin
            expError = arrayHeapPkg::arrayFull;
          end else begin
            modelMem[arr][modelSize[arr]] = data;
            modelSize[arr]++;
            expData = data;
          end
        end
        arrayHeapPkg::actPop: begin
          if (modelSize[arr] == 0) begin
            expError = arrayHeapPkg::arrayEmpty;
          end else begin
            modelSize[arr]--;
            expData = modelMem[arr][modelSize[arr]];
          end
        end
        default: begin                            // Read and the element operations
          if (idx >= modelSize[arr]) begin
            expError = arrayHeapPkg::outOfBounds;
          end else begin
            case (act)
              arrayHeapPkg::actAdd:      value = value + data;
              arrayHeapPkg::actSubtract: value = value - data;
              arrayHeapPkg::actOr:       value = value | data;
              arrayHeapPkg::actXor:      value = value ^ data;
              arrayHeapPkg::actAnd:      value = value & data;
              default: ;
            endcase
            modelMem[arr][idx] = value;
            expData = value;
          end
        end
      endcase
    end
  endtask

  // Reply sampled half a cycle after its clock edge
  task automatic collectReply();
    @(negedge clock);
    if (done !== pending) begin
      reportFail($sformatf("done was %b, expected %b", done, pending));
    end else if (pending && (dataOut !== expData || error !== expError)) begin
      reportFail($sformatf("%s gave data %0h error %s, expected %0h %s", expAction.name(),
                 dataOut, error.name(), expData, expError.name()));
    end
  endtask

  task automatic issue(input arrayHeapPkg::heapAction act, input int arr, input int idx,
                       input arrayHeapPkg::elementData data);
    collectReply();
    start = 1'b1;
    action = act;
    array = arrayHeapPkg::arrayNumber'(arr);
    index = arrayHeapPkg::elementIndex'(idx);
    dataIn = data;
    applyModel(act, arr, idx, data);
    pending = 1'b1;
  endtask

  task automatic idle();
    collectReply();
    start = 1'b0;
    pending = 1'b0;
  endtask

  task automatic finishTest(input string name);
    idle();
    $display("Test %s finished with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  task automatic randomCommand();
    arrayHeapPkg::heapAction act;
    int arr;
    int idx;
    act = actionTable[nextRandom() % 20];
    if (act == arrayHeapPkg::actClear && nextRandom() % 3 != 0) act = arrayHeapPkg::actAlloc;
    arr = nextRandom() % `HEAP_ARRAY_COUNT;
    if (nextRandom() % 4 != 0) begin              // Lean toward arrays in use
      for (int k = 0; k < `HEAP_ARRAY_COUNT && !modelAlloc[arr]; k++) begin
        arr = (arr + 1) % `HEAP_ARRAY_COUNT;
      end
    end
    idx = nextRandom() % `HEAP_ARRAY_LENGTH;
    if (modelSize[arr] > 0 && nextRandom() % 4 != 0) idx = nextRandom() % modelSize[arr];
    issue(act, arr, idx, arrayHeapPkg::elementData'(nextRandom()));
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    start = 1'b0;
    action = arrayHeapPkg::actClear;
    array = '0;
    index = '0;
    dataIn = '0;
    seed = 32'd17;
    pending = 1'b0;
    errors = 0;
    testErrors = 0;
    modelFresh = 0;

    @(posedge resetN);
    @(negedge clock);
    if (done !== 1'b0 || error !== arrayHeapPkg::none || dataOut !== '0) begin
      reportFail("outputs not at reset values");
    end
    issue(arrayHeapPkg::actClear, 0, 0, 12'h0);   // Back to back from here
    issue(arrayHeapPkg::actSize, 1, 0, 12'h0);
    issue(arrayHeapPkg::actAlloc, 0, 0, 12'h0);
    issue(arrayHeapPkg::actSize, 0, 0, 12'h0);
    idle();
    issue(arrayHeapPkg::actPop, 0, 0, 12'h0);
    finishTest("reset and timing");

    issue(arrayHeapPkg::actClear, 0, 0, 12'h0);
    repeat (5) issue(arrayHeapPkg::actAlloc, 0, 0, 12'h0);   // Fifth is out of memory
    issue(arrayHeapPkg::actFree, 2, 0, 12'h0);
    issue(arrayHeapPkg::actFree, 0, 0, 12'h0);
    repeat (2) issue(arrayHeapPkg::actAlloc, 0, 0, 12'h0);   // Gives 0 then 2
    issue(arrayHeapPkg::actFree, 1, 0, 12'h0);
    issue(arrayHeapPkg::actRead, 1, 0, 12'h0);
    issue(arrayHeapPkg::actWrite, 1, 3, 12'h5a5);
    issue(arrayHeapPkg::actFree, 1, 0, 12'h0);
    finishTest("allocation");

    issue(arrayHeapPkg::actClear, 0, 0, 12'h0);
    repeat (4) issue(arrayHeapPkg::actAlloc, 0, 0, 12'h0);
    for (int a = 0; a < `HEAP_ARRAY_COUNT; a++) begin
      for (int i = `HEAP_ARRAY_LENGTH - 1; i >= 0; i--) begin
        issue(arrayHeapPkg::actWrite, a, i, arrayHeapPkg::elementData'(nextRandom()));
      end
      issue(arrayHeapPkg::actSize, a, 0, 12'h0);
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) issue(arrayHeapPkg::actRead, a, i, 12'h0);
    end
    issue(arrayHeapPkg::actFree, 3, 0, 12'h0);
    issue(arrayHeapPkg::actAlloc, 0, 0, 12'h0);
    issue(arrayHeapPkg::actWrite, 3, 2, 12'h123);           // Size grows to 3
    issue(arrayHeapPkg::actSize, 3, 0, 12'h0);
    issue(arrayHeapPkg::actRead, 3, 1, 12'h0);
    issue(arrayHeapPkg::actRead, 3, 3, 12'h0);
    finishTest("write read size");

    repeat (6) issue(arrayHeapPkg::actPush, 3, 0, arrayHeapPkg::elementData'(nextRandom()));
    issue(arrayHeapPkg::actPush, 3, 0, 12'h7ff);
    issue(arrayHeapPkg::actSize, 3, 0, 12'h0);
    repeat (9) issue(arrayHeapPkg::actPop, 3, 0, 12'h0);      // Last pop finds it empty
    issue(arrayHeapPkg::actSize, 3, 0, 12'h0);
    finishTest("push and pop");

    issue(arrayHeapPkg::actWrite, 1, 2, 12'h0ab);
    issue(arrayHeapPkg::actWrite, 1, 5, 12'h0ab);
    issue(arrayHeapPkg::actFind, 1, 0, 12'h0ab);
    issue(arrayHeapPkg::actFind, 1, 0, 12'hfff);
    issue(arrayHeapPkg::actAdd, 1, 0, 12'hfff);
    issue(arrayHeapPkg::actRead, 1, 0, 12'h0);
    for (int i = 0; i < 5; i++) begin
      issue(actionTable[12 + i], 1, i + 1, arrayHeapPkg::elementData'(nextRandom()));
      issue(arrayHeapPkg::actRead, 1, i + 1, 12'h0);
    end
    issue(arrayHeapPkg::actAdd, 3, 0, 12'h001);
    finishTest("find and arithmetic");

    repeat (400) randomCommand();
    finishTest("random mix");

    totalErrors = errors + uut.decoder.decoderChecks.failures;
    $display("Totals: 6 tests, %0d check errors, %0d assertion failures", errors,
             uut.decoder.decoderChecks.failures);
    if (totalErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #((plannedCommands * 20 + 100) * 10);
    $display("Watchdog expired before all tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tests/arrayHeap_assertions.sv
// --------------------------------------------------
// Concurrent checks on the command decoder
// Bound into heapCommandDecoder by the testbench
// --------------------------------------------------

module arrayHeapAssertions (
  input logic clock,
  input logic resetN,
  input logic start,
  input logic done,
  input logic storeEnable,
  input arrayHeapPkg::heapError error,
  input arrayHeapPkg::elementData dataOut
);

  int failures = 0;                     // Count of failed assertions

  doneAfterStart: assert property (@(posedge clock) disable iff (!resetN)
    start |=> done)
    else begin failures++; $error("done missing one cycle after start"); end

  noStrayDone: assert property (@(posedge clock) disable iff (!resetN)
    !start |=> !done)
    else begin failures++; $error("done raised without a start"); end

  // Enabled work must come from a command that passed its checks
  enableMeansNoError: assert property (@(posedge clock) disable iff (!resetN)
    storeEnable |=> error == arrayHeapPkg::none)
    else begin failures++; $error("error reported for an enabled command"); end

  errorClearsData: assert property (@(posedge clock) disable iff (!resetN)
    error != arrayHeapPkg::none |-> dataOut == '0)
    else begin failures++; $error("dataOut not zero alongside an error"); end

endmodule

//--- tests/clockGen.sv
// --------------------------------------------------
// Testbench clock and reset source
// Period of 10, reset held low for the first 8 cycles
// --------------------------------------------------

module clockGen (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;                      // Released away from the active edge
  end

endmodule
